//--- rtl/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 of the ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_WB
    } fwd_sel_e;

    ////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////

    typedef struct packed {
        logic   valid;
        instr_t instr;
        addr_t  pc;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        reg_addr_t rd;
        logic      we;
    } id_ex_t;

    // Also the retire record
    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        word_t     result;
    } wb_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter core_pkg::addr_t RESET_PC = '0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Instruction memory
    output logic             mem_rd_o,
    output core_pkg::addr_t  mem_addr_o,
    input  core_pkg::instr_t mem_rd_data_i,
    input  logic             mem_ready_i,

    // To decode
    output core_pkg::if_id_t if_id_o
);

    import core_pkg::*;

    addr_t  pc_q;
    logic   accept;
    if_id_t if_id_d;
    if_id_t if_id_q;

    // Nothing downstream ever stalls, so fetch always asks for the next word
    assign mem_rd_o   = 1'b1;
    assign mem_addr_o = pc_q;

    // Word is taken on the edge where memory is ready
    assign accept = mem_rd_o && mem_ready_i;

    ////////////////////////////////////////
    // PC
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + addr_t'(4);
        end
    end

    ////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////

    // A cycle without acceptance leaves a bubble
    always_comb begin
        if_id_d.valid = accept;
        if_id_d.instr = mem_rd_data_i;
        if_id_d.pc    = pc_q;
    end

    always_ff @(posedge clk_i) begin
        if_id_q <= if_id_d;
        if (!rst_n_i) begin
            if_id_q.valid <= 1'b0;
        end
    end

    assign if_id_o = if_id_q;

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  core_pkg::if_id_t    if_id_i,

    // Register file read side
    output core_pkg::reg_addr_t rf_raddr_a_o,
    output core_pkg::reg_addr_t rf_raddr_b_o,
    input  core_pkg::word_t     rf_data_a_i,
    input  core_pkg::word_t     rf_data_b_i,

    // Forwarding
    output core_pkg::reg_addr_t src_a_o,
    output core_pkg::reg_addr_t src_b_o,
    output logic                src_a_used_o,
    output logic                src_b_used_o,
    input  core_pkg::fwd_sel_e  sel_a_i,
    input  core_pkg::fwd_sel_e  sel_b_i,
    input  core_pkg::word_t     ex_result_i,
    input  core_pkg::word_t     wb_result_i,

    output core_pkg::id_ex_t    id_ex_o
);

    import core_pkg::*;

    instr_t    instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_u;
    alu_op_e   alu_op;
    logic      legal;
    logic      b_is_imm;
    logic      alt;
    word_t     fwd_a;
    word_t     fwd_b;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;

    function automatic alu_op_e f3_to_op(logic [2:0] f3, logic use_alt);
        case (f3)
            F3_ADD_SUB: return use_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return use_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf, word_t ex, word_t wb);
        case (sel)
            FWD_EX:  return ex;
            FWD_WB:  return wb;
            default: return rf;
        endcase
    endfunction

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    always_comb begin : decode_ctrl
        alt          = 1'b0;
        legal        = 1'b0;
        b_is_imm     = 1'b0;
        src_a_used_o = 1'b0;
        src_b_used_o = 1'b0;
        alu_op       = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                src_a_used_o = 1'b1;
                src_b_used_o = 1'b1;
                alt          = (funct7 == F7_ALT);
                // ALT only exists for SUB and SRA
                legal = (funct7 == F7_BASE) ||
                        (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                alu_op = f3_to_op(funct3, alt);
            end
            OPC_OP_IMM: begin
                src_a_used_o = 1'b1;
                b_is_imm     = 1'b1;
                alt          = (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT);
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    legal = (funct7 == F7_BASE) || alt;
                end else begin
                    legal = 1'b1;
                end
                alu_op = f3_to_op(funct3, alt);
            end
            OPC_LUI: begin
                b_is_imm = 1'b1;
                legal    = 1'b1;
                alu_op   = ALU_PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign rf_raddr_a_o = rs1;
    assign rf_raddr_b_o = rs2;
    assign src_a_o      = rs1;
    assign src_b_o      = rs2;

    // Operands with forwarded values, then immediate for B
    assign fwd_a = fwd_mux(sel_a_i, rf_data_a_i, ex_result_i, wb_result_i);
    assign fwd_b = fwd_mux(sel_b_i, rf_data_b_i, ex_result_i, wb_result_i);

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    always_comb begin
        id_ex_d.valid  = if_id_i.valid;
        id_ex_d.alu_op = alu_op;
        id_ex_d.op_a   = fwd_a;
        id_ex_d.op_b   = b_is_imm ? ((opcode == OPC_LUI) ? imm_u : imm_i) : fwd_b;
        id_ex_d.rd     = rd;
        id_ex_d.we     = legal && (rd != '0);
    end

    always_ff @(posedge clk_i) begin
        id_ex_q <= id_ex_d;
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- rtl/forwarding_unit.sv
`timescale 1ns/100ps

module forwarding_unit (
    input  core_pkg::reg_addr_t src_a_i,
    input  core_pkg::reg_addr_t src_b_i,
    input  logic                src_a_used_i,
    input  logic                src_b_used_i,

    // Producers, write enables already qualified by valid
    input  core_pkg::reg_addr_t ex_rd_i,
    input  logic                ex_we_i,
    input  core_pkg::reg_addr_t wb_rd_i,
    input  logic                wb_we_i,

    output core_pkg::fwd_sel_e  sel_a_o,
    output core_pkg::fwd_sel_e  sel_b_o
);

    import core_pkg::*;

    // Youngest producer first, execute is one instruction ahead
    function automatic fwd_sel_e pick(reg_addr_t src, logic used, reg_addr_t ex_rd,
                                      logic ex_we, reg_addr_t wb_rd, logic wb_we);
        if (!used || src == '0) begin
            return FWD_RF;
        end else if (ex_we && ex_rd == src) begin
            return FWD_EX;
        end else if (wb_we && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign sel_a_o = pick(src_a_i, src_a_used_i, ex_rd_i, ex_we_i, wb_rd_i, wb_we_i);
    assign sel_b_o = pick(src_b_i, src_b_used_i, ex_rd_i, ex_we_i, wb_rd_i, wb_we_i);

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  core_pkg::id_ex_t    id_ex_i,

    // Forwarding from this stage
    output core_pkg::word_t     ex_result_o,
    output core_pkg::reg_addr_t ex_rd_o,
    output logic                ex_we_o,

    output core_pkg::wb_t       wb_o
);

    import core_pkg::*;

    word_t               op_a;
    word_t               op_b;
    logic [SHAMT_W-1:0]  shamt;
    word_t               alu_res;
    wb_t                 wb_d;
    wb_t                 wb_q;

    assign op_a  = id_ex_i.op_a;
    assign op_b  = id_ex_i.op_b;
    assign shamt = op_b[SHAMT_W-1:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin : alu
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_b;
        endcase
    end

    assign ex_result_o = alu_res;
    assign ex_rd_o     = id_ex_i.rd;
    // Bubbles never forward
    assign ex_we_o     = id_ex_i.valid && id_ex_i.we;

    ////////////////////////////////////////
    // EX/WB register
    ////////////////////////////////////////

    always_comb begin
        wb_d.valid  = id_ex_i.valid;
        wb_d.we     = ex_we_o;
        wb_d.rd     = id_ex_i.rd;
        wb_d.result = alu_res;
    end

    always_ff @(posedge clk_i) begin
        wb_q <= wb_d;
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
            wb_q.we    <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- rtl/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  core_pkg::reg_addr_t raddr_a_i,
    input  core_pkg::reg_addr_t raddr_b_i,
    output core_pkg::word_t     rdata_a_o,
    output core_pkg::word_t     rdata_b_o,

    input  core_pkg::wb_t       wb_i
);

    import core_pkg::*;

    // x0 has no storage
    word_t regs [1:31];
    logic  wr_en;

    assign wr_en = rst_n_i && wb_i.valid && wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            regs[wb_i.rd] <= wb_i.result;
        end
    end

    // Same-cycle write is covered by the WB forward path
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- rtl/core_top.sv
`timescale 1ns/100ps

module core_top #(
    parameter core_pkg::addr_t RESET_PC = '0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Instruction memory
    output logic             mem_rd_o,
    output core_pkg::addr_t  mem_addr_o,
    input  core_pkg::instr_t mem_rd_data_i,
    input  logic             mem_ready_i,

    // One record per decoded instruction
    output core_pkg::wb_t    retire_o
);

    import core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    wb_t       wb;

    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    word_t     rf_data_a;
    word_t     rf_data_b;

    reg_addr_t src_a;
    reg_addr_t src_b;
    logic      src_a_used;
    logic      src_b_used;
    fwd_sel_e  sel_a;
    fwd_sel_e  sel_b;

    word_t     ex_result;
    reg_addr_t ex_rd;
    logic      ex_we;

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mem_rd_o      (mem_rd_o),
        .mem_addr_o    (mem_addr_o),
        .mem_rd_data_i (mem_rd_data_i),
        .mem_ready_i   (mem_ready_i),
        .if_id_o       (if_id)
    );

    decode_stage u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .if_id_i      (if_id),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_data_a_i  (rf_data_a),
        .rf_data_b_i  (rf_data_b),
        .src_a_o      (src_a),
        .src_b_o      (src_b),
        .src_a_used_o (src_a_used),
        .src_b_used_o (src_b_used),
        .sel_a_i      (sel_a),
        .sel_b_i      (sel_b),
        .ex_result_i  (ex_result),
        .wb_result_i  (wb.result),
        .id_ex_o      (id_ex)
    );

    // wb.we is only set together with wb.valid
    forwarding_unit u_fwd (
        .src_a_i      (src_a),
        .src_b_i      (src_b),
        .src_a_used_i (src_a_used),
        .src_b_used_i (src_b_used),
        .ex_rd_i      (ex_rd),
        .ex_we_i      (ex_we),
        .wb_rd_i      (wb.rd),
        .wb_we_i      (wb.we),
        .sel_a_o      (sel_a),
        .sel_b_o      (sel_b)
    );

    execute_stage u_execute (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .id_ex_i     (id_ex),
        .ex_result_o (ex_result),
        .ex_rd_o     (ex_rd),
        .ex_we_o     (ex_we),
        .wb_o        (wb)
    );

    register_file u_rf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_data_a),
        .rdata_b_o (rf_data_b),
        .wb_i      (wb)
    );

    assign retire_o = wb;

endmodule

//--- verification/core_props.sv
`timescale 1ns/100ps

module core_props (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             mem_rd_i,
    input  core_pkg::addr_t  mem_addr_i,
    input  logic             mem_ready_i,
    input  core_pkg::wb_t    retire_i
);

    import core_pkg::*;

    logic        accept;
    int unsigned fail_count = 0;

    assign accept = mem_rd_i && mem_ready_i;

    ////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////

    // Request held with the same address until memory answers
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_rd_i && !mem_ready_i) |=> (mem_rd_i && $stable(mem_addr_i)))
        else begin
            $error("fetch request dropped or address moved while memory was not ready");
            fail_count++;
        end

    pc_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |=> (mem_addr_i == $past(mem_addr_i) + addr_t'(4)))
        else begin
            $error("fetch address did not advance by four after an accepted word");
            fail_count++;
        end

    ////////////////////////////////////////
    // Reset and retire port
    ////////////////////////////////////////

    rst_req: assert property (@(posedge clk_i) !rst_n_i |-> mem_rd_i)
        else begin
            $error("fetch request low during reset");
            fail_count++;
        end

    rst_retire: assert property (@(posedge clk_i) !rst_n_i |=> !retire_i.valid)
        else begin
            $error("retire record valid right after a reset cycle");
            fail_count++;
        end

    retire_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(retire_i.valid) &&
        (retire_i.valid -> !$isunknown({retire_i.we, retire_i.rd})))
        else begin
            $error("retire record control fields unknown");
            fail_count++;
        end

    result_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (retire_i.valid && retire_i.we) |-> !$isunknown(retire_i.result))
        else begin
            $error("retired write carries an unknown result");
            fail_count++;
        end

endmodule

bind core_top core_props u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_rd_i    (mem_rd_o),
    .mem_addr_i  (mem_addr_o),
    .mem_ready_i (mem_ready_i),
    .retire_i    (retire_o)
);

//--- verification/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    import core_pkg::*;

    localparam int NUM_RETIRES = 60;
    localparam int MEM_WORDS   = 64;
    localparam int NUM_INIT    = 7;
    localparam int NUM_SWEEP   = 32;
    localparam int X0_AT       = NUM_INIT + NUM_SWEEP;
    localparam int IDLE_LIMIT  = 32;

    // Expected retire record and the edge that accepted its fetch
    typedef struct packed {
        wb_t         rec;
        logic [31:0] acc_edge;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        mem_rd;
    addr_t       mem_addr;
    instr_t      mem_rd_data;
    logic        mem_ready;
    wb_t         retire;

    instr_t      imem [0:MEM_WORDS-1];
    word_t       shadow [0:31];
    expect_t     exp_q [$];
    logic [31:0] rng_state = 32'd41747;
    logic [31:0] edge_cnt = '0;
    addr_t       exp_pc;
    int          delay_left;
    int          retired;
    int          idle;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 32'd1;
    end

    core_top #(
        .RESET_PC (32'h0000_0000)
    ) dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .mem_rd_o      (mem_rd),
        .mem_addr_o    (mem_addr),
        .mem_rd_data_i (mem_rd_data),
        .mem_ready_i   (mem_ready),
        .retire_o      (retire)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic halt_with(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want)
        else halt_with($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                 $time, name, got, want));
    endtask

    function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // Code 0..15 OP, 16..25 OP-IMM, 26..28 LUI, 29..31 outside the kept set
    function automatic instr_t make_instr(logic [4:0] code, reg_addr_t rd);
        logic [31:0] r;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [4:0]  shamt;
        r     = next_rand();
        rs1   = reg_addr_t'(r[2:0]);
        rs2   = reg_addr_t'(r[5:3]);
        shamt = r[10:6];
        if (code < 5'd16) begin
            return enc_r(code[3] ? F7_ALT : F7_BASE, rs2, rs1, code[2:0], rd);
        end else if (code < 5'd24) begin
            if (code[2:0] == F3_SLL || code[2:0] == F3_SRL_SRA) begin
                return enc_i({F7_BASE, shamt}, rs1, code[2:0], rd);
            end
            return enc_i(r[31:20], rs1, code[2:0], rd);
        end
        case (code)
            5'd24:               return enc_i({F7_ALT, shamt}, rs1, F3_SRL_SRA, rd);
            // Not a base shift encoding
            5'd25:               return enc_i({7'b0000001, shamt}, rs1, F3_SRL_SRA, rd);
            5'd26, 5'd27, 5'd28: return {r[31:12], rd, OPC_LUI};
            5'd29:               return {r[31:7], 7'b0000011};
            5'd30:               return {r[31:7], 7'b1100011};
            default:             return {r[31:7], 7'b1101111};
        endcase
    endfunction

    task automatic fill_program();
        logic [31:0] r;
        logic [4:0]  code;
        reg_addr_t   rd;
        for (int n = 0; n < 32; n++) begin
            shadow[n] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = next_rand();
            if (i < NUM_INIT) begin
                // x1..x7 get defined values before anything reads them
                imem[i] = enc_i(r[11:0], 5'd0, F3_ADD_SUB, reg_addr_t'(i + 1));
            end else if (i < NUM_INIT + NUM_SWEEP) begin
                code    = 5'(i - NUM_INIT);
                rd      = reg_addr_t'(r[10:8] % 3'd7) + 5'd1;
                imem[i] = make_instr(code, rd);
            end else if (i == X0_AT) begin
                // Legal ALU write aimed at x0
                imem[i] = enc_r(F7_BASE, 5'd1, 5'd2, F3_ADD_SUB, 5'd0);
            end else if (i == X0_AT + 1) begin
                // Reads x0 right behind that write
                imem[i] = enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd3);
            end else begin
                imem[i] = make_instr(r[4:0], reg_addr_t'(r[7:5]));
            end
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD_SUB: return alt ? a + ~b + 32'd1 : a + b;
            F3_SLL:     return a << sh;
            F3_SLT:     return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            F3_SLTU:    return word_t'(a < b);
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : '0);
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    task automatic predict(input instr_t ins, output wb_t rec);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       ok;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = shadow[ins[19:15]];
        b   = shadow[ins[24:20]];
        ok  = 1'b0;
        res = '0;
        case (opc)
            OPC_OP: begin
                ok = (f7 == F7_BASE) ||
                     (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                res = alu_model(f3, f7 == F7_ALT, a, b);
            end
            OPC_OP_IMM: begin
                b = {{20{ins[31]}}, ins[31:20]};
                if (f3 == F3_SLL) begin
                    ok = (f7 == F7_BASE);
                end else if (f3 == F3_SRL_SRA) begin
                    ok = (f7 == F7_BASE) || (f7 == F7_ALT);
                end else begin
                    ok = 1'b1;
                end
                // Only SRAI picks the arithmetic form through funct7
                res = alu_model(f3, f3 == F3_SRL_SRA && f7 == F7_ALT, a, b);
            end
            OPC_LUI: begin
                ok  = 1'b1;
                res = {ins[31:12], 12'h000};
            end
            default: begin
                ok = 1'b0;
            end
        endcase
        rec.valid  = 1'b1;
        rec.rd     = ins[11:7];
        rec.we     = ok && (ins[11:7] != 5'd0);
        rec.result = res;
        if (rec.we) begin
            shadow[rec.rd] = res;
        end
    endtask

    ////////////////////////////////////////
    // Memory and retire checks
    ////////////////////////////////////////

    task automatic check_retire();
        expect_t e;
        if (retire.valid === 1'b1) begin
            assert (exp_q.size() > 0)
            else halt_with("A retire record appeared with no accepted fetch to match it");
            e = exp_q.pop_front();
            check_eq("retire_o.valid edge", edge_cnt, e.acc_edge + 32'd2);
            check_eq("retire_o.we", 32'(retire.we), 32'(e.rec.we));
            check_eq("retire_o.rd", 32'(retire.rd), 32'(e.rec.rd));
            if (e.rec.we) begin
                check_eq("retire_o.result", retire.result, e.rec.result);
            end
            retired++;
            idle = 0;
        end
    endtask

    task automatic drive_memory();
        instr_t  word;
        expect_t e;
        word = imem[mem_addr[7:2]];
        if (mem_rd === 1'b1) begin
            check_eq("mem_addr_o", mem_addr, exp_pc);
        end
        if (mem_rd === 1'b1 && delay_left == 0) begin
            mem_ready   = 1'b1;
            mem_rd_data = word;
            predict(word, e.rec);
            e.acc_edge  = edge_cnt + 32'd1;
            exp_q.push_back(e);
            exp_pc      = exp_pc + 32'd4;
            delay_left  = int'(next_rand() % 32'd4);
        end else begin
            mem_ready   = 1'b0;
            mem_rd_data = ~word;
            if (mem_rd === 1'b1) begin
                delay_left--;
            end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        mem_ready   = 1'b0;
        mem_rd_data = '0;
        exp_pc      = '0;
        retired     = 0;
        idle        = 0;
        delay_left  = 0;
        fill_program();
        repeat (8) begin
            @(negedge clk);
        end
        rst_n      = 1'b1;
        delay_left = int'(next_rand() % 32'd4);
        while (retired < NUM_RETIRES) begin
            assert (dut.u_props.fail_count == 0)
            else halt_with("A bound protocol assertion on the core ports failed");
            check_retire();
            drive_memory();
            idle++;
            assert (idle <= IDLE_LIMIT)
            else halt_with($sformatf("Timeout: no instruction retired for %0d cycles",
                                     IDLE_LIMIT));
            @(negedge clk);
        end
        if (dut.u_props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            halt_with("A bound protocol assertion on the core ports failed");
        end
    end

endmodule

//--- files.f
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/forwarding_unit.sv
rtl/execute_stage.sv
rtl/register_file.sv
rtl/core_top.sv
verification/core_props.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: core_pipeline

sources:
  - rtl/core_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/forwarding_unit.sv
  - rtl/execute_stage.sv
  - rtl/register_file.sv
  - rtl/core_top.sv
  - target: test
    files:
      - verification/core_props.sv
      - verification/core_tb.sv
